// ==== vlog.f ====
design/tile_map_pkg.sv
design/mem_bus_pkg.sv
design/addr_decoder.sv
design/slave_port_arb.sv
design/resp_router.sv
design/tile_sram.sv
design/tile_xbar_top.sv
verification/xbar_props.sv
verification/tile_xbar_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the tile interconnect testbench with Verilator, runs it, checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f vlog.f --top-module tile_xbar_tb -o tile_xbar_sim \
	&& ./obj_dir/tile_xbar_sim > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "build or run error"; exit 1; }

cat "$LOG"
grep -q "Simulation completed successfully" "$LOG" && echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== verification/tile_xbar_tb.sv ====
// tile interconnect testbench
// two masters run directed and random traffic against a reference memory
// model, read data and read latency are compared per master

module tile_xbar_tb;

	import mem_bus_pkg::*;
	import tile_map_pkg::*;

	localparam int SFR_BIT    = 16;
	localparam int XBUS_BIT   = 31;
	localparam int RD_LAT     = 3;
	localparam int MEM_W      = 64;
	localparam int IDX_W      = $clog2(MEM_W);
	localparam int N_RAND     = 200;   // per master
	localparam int N_TXN      = N_SLAVES * MEM_W + 64 + N_MASTERS * N_RAND;
	localparam int TXN_CYCLES = 2 * RD_LAT + 4;   // worst case per transaction
	localparam int CLK_PERIOD = 100;

	typedef struct packed
	{
		mem_req_t rq;
		logic     no_wait;   // must be acked in its first cycle
	} tb_cmd_t;

	typedef struct packed
	{
		data_t       data;
		logic [31:0] due;   // sampling edge of the response
	} exp_rd_t;

	logic                     clk_i = 1'b0;
	logic                     rst_i = 1'b1;
	mem_req_t [N_MASTERS-1:0] m_req = '0;
	logic     [N_MASTERS-1:0] m_ack;
	mem_rsp_t [N_MASTERS-1:0] m_rsp;

	tb_cmd_t     cmd_q [N_MASTERS][$];
	exp_rd_t     exp_q [N_MASTERS][$];
	tb_cmd_t     cur [N_MASTERS];
	logic        fresh [N_MASTERS];
	data_t       ref_mem [N_SLAVES][MEM_W];
	logic [31:0] busy_until [N_MASTERS][N_SLAVES];
	logic [31:0] cyc = '0;
	logic        rst_q = 1'b0;
	logic        rr_phase = 1'b0;
	logic        rr_has_last = 1'b0;
	logic        rr_last = 1'b0;
	int          rr_seen = 0;
	int          mismatch_cnt = 0;
	int          other_cnt = 0;

	tile_xbar_top
	#(
		.SFR_BITSEL(SFR_BIT), .XBUS_BITSEL(XBUS_BIT)
		, .RD_LATENCY(RD_LAT), .MEM_WORDS(MEM_W)
	) DUT
	(
		.clk_i(clk_i), .rst_i(rst_i), .m_req(m_req), .m_ack(m_ack), .m_rsp(m_rsp)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	always @(posedge clk_i)
		cyc <= cyc + 1;

	// ####################################################################
	// reference model
	// ####################################################################

	function automatic slave_id_t decode_slave(input addr_t a);
		if (a[XBUS_BIT])
			return SLV_XBUS;
		if (a[SFR_BIT])
			return SLV_SFR;
		return SLV_RAM;
	endfunction

	function automatic int word_of(input addr_t a);
		return int'(a[IDX_W+1:2]);
	endfunction

	function automatic data_t expected_word(input slave_id_t s, input addr_t a);
		return ref_mem[s][word_of(a)];
	endfunction

	function automatic data_t fill_word(input addr_t a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
	endfunction

	function automatic addr_t slave_addr(input slave_id_t s, input int w);
		addr_t base;
		base = '0;
		if (s == SLV_XBUS)
			base[XBUS_BIT] = 1'b1;
		else if (s == SLV_SFR)
			base[SFR_BIT] = 1'b1;
		return base | (addr_t'(w) << 2);
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			begin
			mismatch_cnt++;
			$display("MISMATCH at time %0t: %s, got %h expected %h", $time, what, got, exp);
			end
	endtask

	task automatic report_failure(input string msg);
		other_cnt++;
		$display("ERROR at time %0t: %s", $time, msg);
	endtask

	// apply a transferred request to the model
	task automatic accept_req(input int m, input mem_req_t rq);
		slave_id_t s;
		exp_rd_t   e;
		s = decode_slave(rq.addr);
		if (rq.we)
			begin
			for (int b = 0; b < BE_W; b++)
				begin
				if (rq.be[b])
					ref_mem[s][word_of(rq.addr)][b*8 +: 8] = rq.wdata[b*8 +: 8];
				end
			end
		else
			begin
			if (busy_until[m][s] > cyc)
				report_failure($sformatf("master %0d read accepted while a read was in flight", m));
			e.data = expected_word(s, rq.addr);
			e.due  = cyc + RD_LAT;
			busy_until[m][s] = e.due;
			exp_q[m].push_back(e);
			end
	endtask

	task automatic check_rr_grant();
		logic winner;
		if (cur[0].rq.req && cur[1].rq.req
			&& (decode_slave(cur[0].rq.addr) == decode_slave(cur[1].rq.addr)))
			begin
			check_value("acks on a contended slave", 32'($countones(m_ack)), 32'd1);
			winner = m_ack[1];
			if (rr_has_last)
				check_value("round-robin winner", 32'(winner), 32'(!rr_last));
			rr_last     = winner;
			rr_has_last = 1'b1;
			rr_seen++;
			end
	endtask

	// ####################################################################
	// request driver and response compare
	// ####################################################################

	always @(posedge clk_i)
		begin
		if (rst_i)
			begin
			for (int m = 0; m < N_MASTERS; m++)
				begin
				cur[m]   = '0;
				fresh[m] = 1'b0;
				for (int s = 0; s < N_SLAVES; s++)
					busy_until[m][s] = '0;
				end
			m_req <= '0;
			end
		else
			begin
			if (rr_phase)
				check_rr_grant();
			for (int m = 0; m < N_MASTERS; m++)
				begin
				if (cur[m].rq.req)
					begin
					if (fresh[m] && cur[m].no_wait && !m_ack[m])
						report_failure($sformatf("master %0d was not acked at once", m));
					fresh[m] = 1'b0;
					if (m_ack[m])
						begin
						accept_req(m, cur[m].rq);
						cur[m] = '0;
						end
					end
				if (!cur[m].rq.req && (cmd_q[m].size() > 0))
					begin
					cur[m]   = cmd_q[m].pop_front();
					fresh[m] = 1'b1;
					end
				m_req[m] <= cur[m].rq;   // held until acked
				end
			end
		end

	always @(posedge clk_i)
		begin
		exp_rd_t e;
		rst_q <= rst_i;
		if (rst_q)
			begin
			check_value("m_ack around reset", 32'(m_ack), 32'd0);
			for (int m = 0; m < N_MASTERS; m++)
				check_value("resp around reset", 32'(m_rsp[m].resp), 32'd0);
			end
		if (!rst_i)
			begin
			for (int m = 0; m < N_MASTERS; m++)
				begin
				if (m_rsp[m].resp)
					begin
					if (exp_q[m].size() == 0)
						report_failure($sformatf("master %0d got a response it never asked for", m));
					else
						begin
						e = exp_q[m].pop_front();
						check_value("read data", m_rsp[m].rdata, e.data);
						check_value("read response cycle", cyc, e.due);
						end
					end
				end
			end
		end

	// ####################################################################
	// stimulus
	// ####################################################################

	task automatic push_write(input int m, input addr_t a, input be_t be, input data_t d,
		input logic no_wait);
		tb_cmd_t c;
		c.rq    = '{req: 1'b1, we: 1'b1, addr: a, be: be, wdata: d};
		c.no_wait = no_wait;
		cmd_q[m].push_back(c);
	endtask

	task automatic push_read(input int m, input addr_t a, input logic no_wait);
		tb_cmd_t c;
		c.rq    = '{req: 1'b1, we: 1'b0, addr: a, be: '1, wdata: '0};
		c.no_wait = no_wait;
		cmd_q[m].push_back(c);
	endtask

	function automatic logic traffic_drained();
		for (int m = 0; m < N_MASTERS; m++)
			begin
			if ((cmd_q[m].size() > 0) || cur[m].rq.req || (exp_q[m].size() > 0))
				return 1'b0;
			end
		return 1'b1;
	endfunction

	task automatic wait_idle();
		do
			@(negedge clk_i);
		while (!traffic_drained());
	endtask

	initial
		begin
		slave_id_t sl;
		int        wd;
		void'($urandom(32'h9333));
		repeat (10) @(posedge clk_i);
		rst_i <= 1'b0;
		wait_idle();
		for (int s = 0; s < N_SLAVES; s++)   // preload every word
			begin
			for (int w = 0; w < MEM_W; w++)
				push_write(s % N_MASTERS, slave_addr(slave_id_t'(s), w), '1,
					fill_word(slave_addr(slave_id_t'(s), w)), 1'b0);
			end
		wait_idle();
		for (int s = 0; s < N_SLAVES; s++)   // same offset in every target
			push_write(0, slave_addr(slave_id_t'(s), 5), '1, 32'hC0DE_0000 + data_t'(s), 1'b0);
		for (int s = 0; s < N_SLAVES; s++)
			push_read(0, slave_addr(slave_id_t'(s), 5), 1'b0);
		push_read(0, slave_addr(SLV_XBUS, 5) | (addr_t'(1) << SFR_BIT), 1'b0);   // XBUS bit wins
		wait_idle();
		push_write(1, slave_addr(SLV_RAM, 7), 4'b0011, 32'h1234_5678, 1'b0);
		push_write(1, slave_addr(SLV_RAM, 7), 4'b1000, 32'hAB00_0000, 1'b0);
		push_read(1, slave_addr(SLV_RAM, 7), 1'b0);
		push_write(1, slave_addr(SLV_SFR, 7), 4'b0100, 32'h00EE_0000, 1'b0);
		push_read(1, slave_addr(SLV_SFR, 7), 1'b0);
		wait_idle();
		push_write(0, slave_addr(SLV_RAM, 9), '1, 32'h0000_AAAA, 1'b1);   // both in one cycle
		push_write(1, slave_addr(SLV_SFR, 9), '1, 32'h0000_BBBB, 1'b1);
		push_read(0, slave_addr(SLV_XBUS, 9), 1'b1);
		push_read(1, slave_addr(SLV_RAM, 9), 1'b1);
		wait_idle();
		push_read(0, slave_addr(SLV_RAM, 3), 1'b0);   // second read held off
		push_read(0, slave_addr(SLV_RAM, 3), 1'b0);
		push_read(1, slave_addr(SLV_SFR, 3), 1'b0);
		push_read(1, slave_addr(SLV_SFR, 3), 1'b0);
		wait_idle();
		rr_phase = 1'b1;
		for (int i = 0; i < 8; i++)
			begin
			for (int m = 0; m < N_MASTERS; m++)
				push_write(m, slave_addr(SLV_RAM, 16 + 2 * i + m), '1, $urandom, 1'b0);
			end
		wait_idle();
		rr_phase = 1'b0;
		if (rr_seen < 8)
			report_failure("round-robin test saw too little contention between masters");
		for (int i = 0; i < N_RAND; i++)
			begin
			for (int m = 0; m < N_MASTERS; m++)
				begin
				sl = slave_id_t'($urandom_range(N_SLAVES - 1, 0));
				wd = int'($urandom_range(15, 0));
				if ($urandom_range(1, 0) == 1)
					push_write(m, slave_addr(sl, wd), be_t'($urandom_range(15, 1)), $urandom,
						1'b0);
				else
					push_read(m, slave_addr(sl, wd), 1'b0);
				end
			end
		wait_idle();
		$display("closing report: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
		if ((mismatch_cnt == 0) && (other_cnt == 0))
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
		end

	initial
		begin
		#(N_TXN * TXN_CYCLES * CLK_PERIOD);
		$display("ERROR: watchdog expired, traffic of %0d transactions never drained", N_TXN);
		$display("Simulation failed");
		$finish;
		end

endmodule

// ==== verification/xbar_props.sv ====
// interconnect protocol properties
// bound into the top, checks grant and response rules at the master ports

module xbar_props
#(
	parameter int RD_LATENCY = 1
)
(
	input logic clk_i
	, input logic rst_i
	, input mem_bus_pkg::mem_req_t [tile_map_pkg::N_MASTERS-1:0] m_req
	, input logic [tile_map_pkg::N_MASTERS-1:0] m_ack
	, input mem_bus_pkg::mem_rsp_t [tile_map_pkg::N_MASTERS-1:0] m_rsp
	, input logic [tile_map_pkg::N_MASTERS-1:0][tile_map_pkg::N_SLAVES-1:0] lane_ack
);

	import mem_bus_pkg::*;
	import tile_map_pkg::*;

	logic [N_MASTERS-1:0] rd_take;   // read transferred this cycle

	for (genvar m = 0; m < N_MASTERS; m++)
		begin : g_master
		assign rd_take[m] = m_req[m].req && !m_req[m].we && m_ack[m];

		a_rsp_expected: assert property (@(posedge clk_i) disable iff (rst_i)
			m_rsp[m].resp |-> $past(rd_take[m], RD_LATENCY))
			else $error("master %0d got a response with no read behind it", m);

		a_ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
			m_ack[m] |-> m_req[m].req)
			else $error("master %0d acked without a request", m);

		a_reset_quiet: assert property (@(posedge clk_i)
			rst_i |=> (!m_ack[m] && !m_rsp[m].resp))
			else $error("master %0d port active right after a reset cycle", m);
		end

	for (genvar s = 0; s < N_SLAVES; s++)
		begin : g_slave
		logic [N_MASTERS-1:0] col;   // acks seen on this lane
		for (genvar m = 0; m < N_MASTERS; m++)
			begin : g_col
			assign col[m] = lane_ack[m][s];
			end

		a_one_ack: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(col))
			else $error("slave %0d acked more than one master in a cycle", s);
		end

endmodule

bind tile_xbar_top xbar_props #(.RD_LATENCY(RD_LATENCY)) u_props
(
	.clk_i(clk_i), .rst_i(rst_i), .m_req(m_req), .m_ack(m_ack), .m_rsp(m_rsp)
	, .lane_ack(lane_ack)
);

// ==== design/tile_xbar_top.sv ====
// tile memory interconnect
// two bus masters reach RAM, SFR and external-bus targets through
// a decoder, one round-robin port per target and a response router

module tile_xbar_top
#(
	parameter int SFR_BITSEL = 16
	, parameter int XBUS_BITSEL = 31
	, parameter int RD_LATENCY = 1
	, parameter int MEM_WORDS = 256
)
(
	input logic clk_i
	, input logic rst_i
	, input mem_bus_pkg::mem_req_t [tile_map_pkg::N_MASTERS-1:0] m_req
	, output logic [tile_map_pkg::N_MASTERS-1:0] m_ack
	, output mem_bus_pkg::mem_rsp_t [tile_map_pkg::N_MASTERS-1:0] m_rsp
);

	import mem_bus_pkg::*;
	import tile_map_pkg::*;

	mem_req_t [N_MASTERS-1:0][N_SLAVES-1:0] lane_req;
	logic     [N_MASTERS-1:0][N_SLAVES-1:0] lane_ack;
	mem_req_t [N_SLAVES-1:0][N_MASTERS-1:0] port_req;   // lanes seen per slave
	logic     [N_SLAVES-1:0][N_MASTERS-1:0] port_ack;
	mem_req_t    [N_SLAVES-1:0] s_req;
	mem_rsp_t    [N_SLAVES-1:0] s_rsp;
	tagged_rsp_t [N_SLAVES-1:0] t_rsp;

	addr_decoder #(.SFR_BITSEL(SFR_BITSEL), .XBUS_BITSEL(XBUS_BITSEL)) u_dec
	(
		.m_req(m_req)
		, .lane_ack(lane_ack)
		, .lane_req(lane_req)
		, .m_ack(m_ack)
	);

	// ####################################################################
	// one arbiter and one SRAM per slave
	// ####################################################################

	for (genvar k = 0; k < N_SLAVES; k++)
		begin : g_slave
		for (genvar m = 0; m < N_MASTERS; m++)
			begin : g_lane
			assign port_req[k][m] = lane_req[m][k];
			assign lane_ack[m][k] = port_ack[k][m];
			end

		slave_port_arb u_arb
		(
			.clk_i(clk_i), .rst_i(rst_i)
			, .lane_req(port_req[k]), .lane_ack(port_ack[k])
			, .s_req(s_req[k]), .s_rsp(s_rsp[k]), .t_rsp(t_rsp[k])
		);

		tile_sram #(.MEM_WORDS(MEM_WORDS), .RD_LATENCY(RD_LATENCY)) u_sram
		(
			.clk_i(clk_i), .rst_i(rst_i), .s_req(s_req[k]), .s_rsp(s_rsp[k])
		);
		end

	resp_router u_router (.t_rsp(t_rsp), .m_rsp(m_rsp));

endmodule

// ==== design/tile_sram.sv ====
// tile SRAM target
// word-addressed memory with byte enables on writes
// ready every cycle, reads return after a fixed latency as a resp pulse

module tile_sram
#(
	parameter int MEM_WORDS = 256
	, parameter int RD_LATENCY = 1
)
(
	input logic clk_i
	, input logic rst_i
	, input mem_bus_pkg::mem_req_t s_req
	, output mem_bus_pkg::mem_rsp_t s_rsp
);

	import mem_bus_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	typedef logic [IDX_W-1:0] word_idx_t;

	data_t                 mem [MEM_WORDS];
	word_idx_t             word_idx;
	logic [RD_LATENCY-1:0] pipe_vld;
	data_t                 pipe_data [RD_LATENCY];

	assign word_idx = s_req.addr[IDX_W+1:2];   // byte address to word

	// ####################################################################
	// write port
	// ####################################################################

	always_ff @(posedge clk_i)
		begin
		if (s_req.req && s_req.we)
			begin
			for (int b = 0; b < BE_W; b++)
				begin
				if (s_req.be[b])
					mem[word_idx][b*8 +: 8] <= s_req.wdata[b*8 +: 8];
				end
			end
		end

	// ####################################################################
	// read pipe
	// ####################################################################

	always_ff @(posedge clk_i)
		begin
		if (rst_i)
			pipe_vld <= '0;
		else
			begin
			pipe_vld[0] <= s_req.req && !s_req.we;
			for (int i = 1; i < RD_LATENCY; i++)
				pipe_vld[i] <= pipe_vld[i-1];
			end
		end

	always_ff @(posedge clk_i)
		begin
		if (s_req.req && !s_req.we)
			pipe_data[0] <= mem[word_idx];
		for (int i = 1; i < RD_LATENCY; i++)
			pipe_data[i] <= pipe_data[i-1];
		end

	assign s_rsp.resp  = pipe_vld[RD_LATENCY-1];
	assign s_rsp.rdata = pipe_data[RD_LATENCY-1];

endmodule

// ==== design/resp_router.sv ====
// response router
// hands each tagged slave response to the master named in its tag
// a master sees zero when none of the slaves answers it

module resp_router
(
	input mem_bus_pkg::tagged_rsp_t [tile_map_pkg::N_SLAVES-1:0] t_rsp
	, output mem_bus_pkg::mem_rsp_t [tile_map_pkg::N_MASTERS-1:0] m_rsp
);

	import mem_bus_pkg::*;
	import tile_map_pkg::*;

	logic [N_MASTERS-1:0][N_SLAVES-1:0] hit;   // slave s answers master m

	always_comb
		begin
		for (int m = 0; m < N_MASTERS; m++)
			begin
			for (int s = 0; s < N_SLAVES; s++)
				hit[m][s] = t_rsp[s].rsp.resp && (t_rsp[s].owner == master_id_t'(m));
			end
		end

	// equal latency on all targets, so at most one hit per master
	always_comb
		begin
		m_rsp = '0;
		for (int m = 0; m < N_MASTERS; m++)
			begin
			for (int s = 0; s < N_SLAVES; s++)
				begin
				if (hit[m][s])
					m_rsp[m] = t_rsp[s].rsp;
				end
			end
		end

endmodule

// ==== design/slave_port_arb.sv ====
// slave port arbiter
// round-robin grant of one master per cycle onto a single target,
// tracks one outstanding read per master and marks each returning
// read response with the master that issued it

module slave_port_arb
(
	input logic clk_i
	, input logic rst_i
	, input mem_bus_pkg::mem_req_t [tile_map_pkg::N_MASTERS-1:0] lane_req
	, output logic [tile_map_pkg::N_MASTERS-1:0] lane_ack
	, output mem_bus_pkg::mem_req_t s_req
	, input mem_bus_pkg::mem_rsp_t s_rsp
	, output mem_bus_pkg::tagged_rsp_t t_rsp
);

	import mem_bus_pkg::*;
	import tile_map_pkg::*;

	logic [N_MASTERS-1:0] rd_busy;       // read in progress per master
	logic [N_MASTERS-1:0] rd_busy_eff;   // arriving response retires it
	logic [N_MASTERS-1:0] eligible;
	master_id_t           rr_ptr;        // first master to look at
	master_id_t           rr_cand;
	master_id_t           gnt_id;
	logic                 gnt_vld;

	// ####################################################################
	// grant
	// ####################################################################

	assign rd_busy_eff = s_rsp.resp ? '0 : rd_busy;

	// a read also waits for reads of other masters, keeps owners unambiguous
	always_comb
		begin
		for (int m = 0; m < N_MASTERS; m++)
			eligible[m] = lane_req[m].req && !rd_busy_eff[m]
				&& (lane_req[m].we || (rd_busy_eff == '0));
		end

	always_comb
		begin
		gnt_vld = 1'b0;
		gnt_id  = rr_ptr;
		rr_cand = rr_ptr;
		for (int i = 0; i < N_MASTERS; i++)
			begin
			rr_cand = master_id_t'((int'(rr_ptr) + i) % N_MASTERS);
			if (!gnt_vld && eligible[rr_cand])
				begin
				gnt_vld = 1'b1;
				gnt_id  = rr_cand;
				end
			end
		end

	always_comb
		begin
		lane_ack = '0;
		s_req    = '0;
		if (gnt_vld)
			begin
			lane_ack[gnt_id] = 1'b1;
			s_req            = lane_req[gnt_id];
			end
		end

	// ####################################################################
	// state
	// ####################################################################

	always_ff @(posedge clk_i)
		begin
		if (rst_i)
			begin
			rr_ptr  <= '0;
			rd_busy <= '0;
			end
		else
			begin
			rd_busy <= rd_busy_eff;
			if (gnt_vld && !s_req.we)
				rd_busy[gnt_id] <= 1'b1;
			if (gnt_vld && ($countones(eligible) > 1))
				rr_ptr <= master_id_t'((int'(gnt_id) + 1) % N_MASTERS);   // pass the winner
			end
		end

	// owner is the master still marked busy before this response
	always_comb
		begin
		t_rsp     = '0;
		t_rsp.rsp = s_rsp;
		for (int m = 0; m < N_MASTERS; m++)
			begin
			if (rd_busy[m])
				t_rsp.owner = master_id_t'(m);
			end
		end

endmodule

// ==== design/addr_decoder.sv ====
// address decoder
// sorts each master request onto one slave lane by two address bits,
// XBUS bit first, then SFR bit, RAM otherwise
// folds the per-lane acks back into one ack per master

module addr_decoder
#(
	parameter int SFR_BITSEL = 16
	, parameter int XBUS_BITSEL = 31
)
(
	input mem_bus_pkg::mem_req_t [tile_map_pkg::N_MASTERS-1:0] m_req
	, input logic [tile_map_pkg::N_MASTERS-1:0][tile_map_pkg::N_SLAVES-1:0] lane_ack
	, output mem_bus_pkg::mem_req_t
		[tile_map_pkg::N_MASTERS-1:0][tile_map_pkg::N_SLAVES-1:0] lane_req
	, output logic [tile_map_pkg::N_MASTERS-1:0] m_ack
);

	import mem_bus_pkg::*;
	import tile_map_pkg::*;

	slave_id_t [N_MASTERS-1:0] sel;   // decoded target per master

	always_comb
		begin
		for (int m = 0; m < N_MASTERS; m++)
			begin
			if (m_req[m].addr[XBUS_BITSEL])
				sel[m] = SLV_XBUS;
			else if (m_req[m].addr[SFR_BITSEL])
				sel[m] = SLV_SFR;
			else
				sel[m] = SLV_RAM;
			end
		end

	// request goes out on the decoded lane, other lanes stay idle
	always_comb
		begin
		for (int m = 0; m < N_MASTERS; m++)
			begin
			for (int s = 0; s < N_SLAVES; s++)
				begin
				if (sel[m] == slave_id_t'(s))
					lane_req[m][s] = m_req[m];
				else
					lane_req[m][s] = '0;
				end
			end
		end

	always_comb
		begin
		for (int m = 0; m < N_MASTERS; m++)
			m_ack[m] = |lane_ack[m];   // only the active lane can ack
		end

endmodule

// ==== design/mem_bus_pkg.sv ====
// memory bus definitions
// split-transaction bus shared by both masters and all targets
// a request is taken by ack in its own cycle, read data comes back later as resp

package mem_bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int BE_W   = DATA_W / 8;

	// ####################################################################
	// plain vector types
	// ####################################################################

	typedef logic [ADDR_W-1:0] addr_t;   // byte address
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [BE_W-1:0]   be_t;     // one bit per byte lane

	// ####################################################################
	// bus structs
	// ####################################################################

	// master to target, 70 bits
	typedef struct packed
	{
		logic  req;
		logic  we;      // 1 = write, 0 = read
		addr_t addr;
		be_t   be;
		data_t wdata;
	} mem_req_t;

	// target to master, 33 bits
	typedef struct packed
	{
		logic  resp;    // one cycle per read
		data_t rdata;
	} mem_rsp_t;

	// response after a slave port, marked with the master it belongs to
	typedef struct packed
	{
		mem_rsp_t                 rsp;
		tile_map_pkg::master_id_t owner;
	} tagged_rsp_t;

endpackage

// ==== design/tile_map_pkg.sv ====
// tile map definitions
// counts of bus masters and memory targets, plus their index types
// slave index order follows the address decode priority

package tile_map_pkg;

	localparam int N_MASTERS = 2;
	localparam int N_SLAVES  = 3;

	localparam int MASTER_ID_W = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;
	localparam int SLAVE_ID_W  = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

	typedef logic [MASTER_ID_W-1:0] master_id_t;   // 1 bit
	typedef logic [SLAVE_ID_W-1:0]  slave_id_t;    // 2 bits

	// ####################################################################
	// target indices
	// ####################################################################

	localparam slave_id_t SLV_RAM  = 2'd0;   // local RAM
	localparam slave_id_t SLV_SFR  = 2'd1;   // special-function registers
	localparam slave_id_t SLV_XBUS = 2'd2;   // external-bus window

endpackage
